//--- logic/afe_pkg.sv
// Widths, register map, bus states and sample types shared by all analog front end blocks
package afe_pkg;

  ////////////////////////////////////////////////////////////
  // Channel counts and widths
  ////////////////////////////////////////////////////////////

  // Loopback pairs ADC and DAC channels by index
  localparam int unsigned NUM_ADC        = 2;
  localparam int unsigned NUM_DAC        = 2;
  localparam int unsigned ADC_WIDTH      = 16;
  localparam int unsigned SAMPLE_WIDTH   = 14;
  // PDM outputs, one 8-bit level each
  localparam int unsigned PDM_CHANNELS   = 4;
  localparam int unsigned PDM_WIDTH      = 8;
  localparam int unsigned PDM_RANGE      = 255;
  // Word addressed register bus
  localparam int unsigned REG_ADDR_WIDTH = 3;
  localparam int unsigned WB_DATA_WIDTH  = 32;
  // Identification word, ASCII "AFE1"
  localparam logic [WB_DATA_WIDTH-1:0] AFE_ID = 32'h4146_4531;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  typedef logic        [ADC_WIDTH-1:0]    adc_word_t;
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic        [SAMPLE_WIDTH-1:0] dac_code_t;
  typedef logic        [PDM_WIDTH-1:0]    pdm_level_t;

  // Register map, address 7 left unmapped
  typedef enum logic [REG_ADDR_WIDTH-1:0] {
    REG_ID   = 3'd0,
    REG_LOOP = 3'd1,
    REG_GEN0 = 3'd2,
    REG_GEN1 = 3'd3,
    REG_PDM  = 3'd4,
    REG_ADC0 = 3'd5,
    REG_ADC1 = 3'd6
  } reg_addr_e;

  // Classic bus slave handshake states
  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_ACK  = 1'b1
  } wb_state_e;

  // Keep the top bit, invert the rest
  // Two's complement to offset binary with negative slope, and back
  function automatic logic [SAMPLE_WIDTH-1:0] offset_flip(input logic [SAMPLE_WIDTH-1:0] v);
    return {v[SAMPLE_WIDTH-1], ~v[SAMPLE_WIDTH-2:0]};
  endfunction

endpackage

//--- logic/afe_reg_decode.sv
// Wishbone classic register slave holding loopback, generator and PDM configuration
`timescale 1ns/1ns

module afe_reg_decode (
  input  logic                                          adc_clk,
  input  logic                                          top_rst,
  // Wishbone classic slave
  input  logic                                          wb_cyc_i,
  input  logic                                          wb_stb_i,
  input  logic                                          wb_we_i,
  input  afe_pkg::reg_addr_e                            wb_adr_i,
  input  logic [afe_pkg::WB_DATA_WIDTH-1:0]             wb_dat_i,
  output logic [afe_pkg::WB_DATA_WIDTH-1:0]             wb_dat_o,
  output logic                                          wb_ack_o,
  // Live samples for read-back
  input  afe_pkg::sample_t   [afe_pkg::NUM_ADC-1:0]     adc_sample_i,
  // Configuration outputs
  output logic               [afe_pkg::NUM_ADC-1:0]     loop_en_o,
  output afe_pkg::sample_t   [afe_pkg::NUM_DAC-1:0]     gen_level_o,
  output afe_pkg::pdm_level_t [afe_pkg::PDM_CHANNELS-1:0] pdm_level_o
);

  import afe_pkg::*;

  wb_state_e                state_q;
  // Request accepted in idle, acked on the next edge
  logic                     bus_req;
  logic [WB_DATA_WIDTH-1:0] rd_data;

  // Sign extension of a sample to bus width
  function automatic logic [WB_DATA_WIDTH-1:0] sext(input sample_t value);
    return {{(WB_DATA_WIDTH-SAMPLE_WIDTH){value[SAMPLE_WIDTH-1]}}, value};
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus handshake FSM
  ////////////////////////////////////////////////////////////

  assign bus_req = (state_q == WB_IDLE) && wb_cyc_i && wb_stb_i;

  // Ack lasts one cycle, then one forced idle cycle
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q <= WB_IDLE;
    end else begin
      state_q <= bus_req ? WB_ACK : WB_IDLE;
    end
  end

  assign wb_ack_o = (state_q == WB_ACK);

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  // Writes land on the edge that raises ack
  // Read-only and unmapped addresses fall through
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop_en_o   <= '0;
      gen_level_o <= '0;
      pdm_level_o <= '0;
    end else if (bus_req && wb_we_i) begin
      case (wb_adr_i)
        REG_LOOP: loop_en_o      <= wb_dat_i[NUM_ADC-1:0];
        REG_GEN0: gen_level_o[0] <= wb_dat_i[SAMPLE_WIDTH-1:0];
        REG_GEN1: gen_level_o[1] <= wb_dat_i[SAMPLE_WIDTH-1:0];
        // Channel 0 sits in the low byte
        REG_PDM:  pdm_level_o    <= wb_dat_i[PDM_CHANNELS*PDM_WIDTH-1:0];
        default:  ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      REG_ID:   rd_data = AFE_ID;
      // Unused loop bits stay zero
      REG_LOOP: rd_data[NUM_ADC-1:0] = loop_en_o;
      REG_GEN0: rd_data = sext(gen_level_o[0]);
      REG_GEN1: rd_data = sext(gen_level_o[1]);
      REG_PDM:  rd_data = pdm_level_o;
      REG_ADC0: rd_data = sext(adc_sample_i[0]);
      REG_ADC1: rd_data = sext(adc_sample_i[1]);
      default:  rd_data = '0;
    endcase
  end

  // Captured with the request, valid while ack is high
  always_ff @(posedge adc_clk) begin
    if (bus_req) begin
      wb_dat_o <= rd_data;
    end
  end

  // Every ack is followed by an idle cycle without ack
  a_ack_single: assert property (@(posedge adc_clk) disable iff (top_rst)
    (state_q == WB_ACK) |=> (state_q == WB_IDLE) && !wb_ack_o);

endmodule

//--- logic/adc_sample_path.sv
// ADC input registers, 16-bit to signed 14-bit conversion and digital loopback per channel
`timescale 1ns/1ns

module adc_sample_path (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  input  afe_pkg::adc_word_t [afe_pkg::NUM_ADC-1:0] adc_dat_i,
  input  logic               [afe_pkg::NUM_ADC-1:0] loop_en_i,
  input  afe_pkg::sample_t   [afe_pkg::NUM_DAC-1:0] gen_level_i,
  output afe_pkg::sample_t   [afe_pkg::NUM_ADC-1:0] adc_sample_o
);

  import afe_pkg::*;

  // Loopback needs a generator for every ADC channel
  if (NUM_DAC != NUM_ADC) begin : g_size_check
    $error("Loopback requires NUM_DAC equal to NUM_ADC");
  end

  for (genvar ch = 0; ch < NUM_ADC; ch++) begin : g_chan
    adc_word_t adc_raw_q;
    sample_t   adc_conv;
    sample_t   sample_q;

    // Stage 1, raw word straight from the pins
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        adc_raw_q <= '0;
      end else begin
        adc_raw_q <= adc_dat_i[ch];
      end
    end

    // Top 14 bits only, the two LSBs are below the converter resolution
    assign adc_conv = offset_flip(adc_raw_q[ADC_WIDTH-1 -: SAMPLE_WIDTH]);

    // Stage 2, loopback mux replaces the sample with the generator level
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        sample_q <= '0;
      end else begin
        sample_q <= loop_en_i[ch] ? gen_level_i[ch] : adc_conv;
      end
    end

    assign adc_sample_o[ch] = sample_q;
  end

endmodule

//--- logic/dac_code_format.sv
// Registered conversion of signed generator levels to offset negative-slope DAC codes
`timescale 1ns/1ns

module dac_code_format (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  input  afe_pkg::sample_t   [afe_pkg::NUM_DAC-1:0] gen_level_i,
  output afe_pkg::dac_code_t [afe_pkg::NUM_DAC-1:0] dac_code_o
);

  import afe_pkg::*;

  for (genvar ch = 0; ch < NUM_DAC; ch++) begin : g_chan
    dac_code_t code_q;

    // Level zero maps to mid-scale code 0x1FFF
    // Positive levels give lower codes
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        code_q <= offset_flip('0);
      end else begin
        code_q <= offset_flip(gen_level_i[ch]);
      end
    end

    // One output port per converter channel
    assign dac_code_o[ch] = code_q;
  end

endmodule

//--- logic/pdm_modulator.sv
// Four-channel first-order pulse density modulator with a fixed period of 255 cycles
`timescale 1ns/1ns

module pdm_modulator (
  input  logic                                           adc_clk,
  input  logic                                           top_rst,
  input  afe_pkg::pdm_level_t [afe_pkg::PDM_CHANNELS-1:0] level_i,
  output logic                [afe_pkg::PDM_CHANNELS-1:0] pdm_o
);

  import afe_pkg::*;

  for (genvar ch = 0; ch < PDM_CHANNELS; ch++) begin : g_chan
    // Accumulator always below PDM_RANGE
    pdm_level_t       acc_q;
    // One extra bit for the carry
    logic [PDM_WIDTH:0] acc_sum;
    logic             pdm_q;

    assign acc_sum = {1'b0, acc_q} + {1'b0, level_i[ch]};

    // Each wrap past the range emits a one
    // Constant level L gives exactly L ones per 255 cycles
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc_q <= '0;
        pdm_q <= 1'b0;
      end else if (acc_sum >= PDM_RANGE) begin
        acc_q <= PDM_WIDTH'(acc_sum - PDM_RANGE);
        pdm_q <= 1'b1;
      end else begin
        acc_q <= acc_sum[PDM_WIDTH-1:0];
        pdm_q <= 1'b0;
      end
    end

    assign pdm_o[ch] = pdm_q;

    // Remainder never reaches the period, also for level 255
    a_acc_range: assert property (@(posedge adc_clk) disable iff (top_rst)
      acc_q < PDM_RANGE);
  end

endmodule

//--- logic/analog_front_top.sv
// Analog front end top level joining register decode, ADC sample path, DAC and PDM stages
`timescale 1ns/1ns

module analog_front_top (
  input  logic                                           adc_clk,
  input  logic                                           top_rst,
  // Wishbone classic slave
  input  logic                                           wb_cyc_i,
  input  logic                                           wb_stb_i,
  input  logic                                           wb_we_i,
  input  afe_pkg::reg_addr_e                             wb_adr_i,
  input  logic [afe_pkg::WB_DATA_WIDTH-1:0]              wb_dat_i,
  output logic [afe_pkg::WB_DATA_WIDTH-1:0]              wb_dat_o,
  output logic                                           wb_ack_o,
  // Converter pins
  input  afe_pkg::adc_word_t  [afe_pkg::NUM_ADC-1:0]     adc_dat_i,
  output afe_pkg::dac_code_t  [afe_pkg::NUM_DAC-1:0]     dac_code_o,
  output logic                [afe_pkg::PDM_CHANNELS-1:0] pdm_o
);

  import afe_pkg::*;

  // Configuration from the register block
  logic       [NUM_ADC-1:0]      loop_en;
  sample_t    [NUM_DAC-1:0]      gen_level;
  pdm_level_t [PDM_CHANNELS-1:0] pdm_level;
  // Samples back to the register block
  sample_t    [NUM_ADC-1:0]      adc_sample;

  ////////////////////////////////////////////////////////////
  // Register decode
  ////////////////////////////////////////////////////////////

  afe_reg_decode u_reg_decode (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .adc_sample_i (adc_sample),
    .loop_en_o    (loop_en),
    .gen_level_o  (gen_level),
    .pdm_level_o  (pdm_level)
  );

  ////////////////////////////////////////////////////////////
  // Sample path and output stages
  ////////////////////////////////////////////////////////////

  // Two register stages from pins to read-back
  adc_sample_path u_adc_sample_path (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .adc_dat_i    (adc_dat_i),
    .loop_en_i    (loop_en),
    .gen_level_i  (gen_level),
    .adc_sample_o (adc_sample)
  );

  dac_code_format u_dac_code_format (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .gen_level_i (gen_level),
    .dac_code_o  (dac_code_o)
  );

  pdm_modulator u_pdm_modulator (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .level_i (pdm_level),
    .pdm_o   (pdm_o)
  );

endmodule

//--- sim/analog_front_tb.sv
// Self-checking testbench for the analog front end that runs as the simulation top
`timescale 1ns/1ns

module analog_front_tb;

  import afe_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYCLES  = 8;
  localparam int ACK_LIMIT   = 16;
  localparam int RAND_ROUNDS = 8;
  localparam int ADC_ROUNDS  = 8;
  localparam int DAC_ROUNDS  = 4;
  localparam int PDM_ROUNDS  = 3;
  // Bus operations summed over all sections
  localparam int BUS_OPS = 4 + RAND_ROUNDS * 8 + 1 + ADC_ROUNDS * 2 + NUM_ADC * 6
                           + DAC_ROUNDS * 2 + PDM_ROUNDS;
  localparam int RUN_CYCLES = RST_CYCLES + BUS_OPS * 20 + PDM_ROUNDS * (PDM_RANGE + 16) + 200;

  logic                          adc_clk;
  logic                          top_rst;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic                          wb_ack;
  reg_addr_e                     wb_adr;
  logic [WB_DATA_WIDTH-1:0]      wb_dat_w;
  logic [WB_DATA_WIDTH-1:0]      wb_dat_r;
  adc_word_t  [NUM_ADC-1:0]      adc_dat;
  dac_code_t  [NUM_DAC-1:0]      dac_code;
  logic       [PDM_CHANNELS-1:0] pdm;

  logic       [31:0]             lfsr;
  // Register model updated on every write
  logic       [NUM_ADC-1:0]      m_loop;
  sample_t                       m_gen [NUM_DAC];
  pdm_level_t [PDM_CHANNELS-1:0] m_pdm;
  // Results waiting for the comparing process
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];
  string       msg_q[$];
  event        got_ev;
  int          n_expected = 0;
  int          n_checked = 0;

  analog_front_top UUT (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .adc_dat_i  (adc_dat),
    .dac_code_o (dac_code),
    .pdm_o      (pdm)
  );

  initial begin : clock_gen
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // Top 14 bits of the word with magnitude bits flipped
  function automatic sample_t ref_adc_sample(input adc_word_t word);
    return sample_t'((word >> 2) ^ 16'h1FFF);
  endfunction

  // Offset code with negative slope
  function automatic dac_code_t ref_dac_code(input sample_t level);
    return dac_code_t'(level) ^ 14'h1FFF;
  endfunction

  // Ones in a window of whole modulator periods
  function automatic int ref_pdm_ones(input pdm_level_t level, input int window);
    return int'(level) * window / int'(PDM_RANGE);
  endfunction

  // Expected read data with samples and levels sign-extended
  function automatic logic [31:0] ref_read(input logic [2:0] addr);
    case (addr)
      REG_ID:             return AFE_ID;
      REG_LOOP:           return 32'(m_loop);
      REG_GEN0, REG_GEN1: return 32'(m_gen[addr[0]]);
      REG_PDM:            return m_pdm;
      // Loopback takes the generator of the same channel
      REG_ADC0, REG_ADC1: return m_loop[addr[1]] ? 32'(m_gen[addr[1]])
                                                 : 32'(ref_adc_sample(adc_dat[addr[1]]));
      default:            return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                input string msg);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s, expected %h, got %h", $time, msg, exp, got);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
    got_q.push_back(got);
    exp_q.push_back(exp);
    msg_q.push_back(msg);
    n_expected++;
    -> got_ev;
  endtask

  initial begin : compare_proc
    forever begin
      @(got_ev);
      while (got_q.size() > 0) begin
        compare_values(got_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
        n_checked++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus and output tasks
  ////////////////////////////////////////////////////////////

  // Classic cycle held until ack shows on a falling edge
  task automatic bus_access(input logic we, input logic [2:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    int ack_wait;
    waited = 0;
    // An ack still high means the slave spends the next cycle in idle
    ack_wait = wb_ack ? 2 : 1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = reg_addr_e'(addr);
    wb_dat_w = wdata;
    do begin
      @(negedge adc_clk);
      waited++;
      if (waited > ACK_LIMIT) begin
        $display("Bus access to address %0d got no ack within %0d cycles", addr, ACK_LIMIT);
        $display("SOME TESTS FAILED");
        $fatal(1, "Bus handshake timed out");
      end
    end while (!wb_ack);
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    expect_value(waited, ack_wait, "ack latency in cycles");
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
    case (addr)
      REG_LOOP: m_loop = data[NUM_ADC-1:0];
      REG_GEN0: m_gen[0] = data[SAMPLE_WIDTH-1:0];
      REG_GEN1: m_gen[1] = data[SAMPLE_WIDTH-1:0];
      REG_PDM:  m_pdm = data;
      default:  ;
    endcase
  endtask

  task automatic read_and_expect(input logic [2:0] addr, input string msg);
    logic [31:0] data;
    bus_access(1'b0, addr, '0, data);
    expect_value(data, ref_read(addr), msg);
  endtask

  task automatic check_dac_codes(input string msg);
    for (int ch = 0; ch < NUM_DAC; ch++) begin
      expect_value(32'(dac_code[ch]), 32'(ref_dac_code(m_gen[ch])), msg);
    end
  endtask

  // One full period per channel sampled on falling edges
  task automatic count_pdm_ones();
    int ones [PDM_CHANNELS];
    ones = '{default: 0};
    repeat (PDM_RANGE) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < PDM_CHANNELS; ch++) begin
        ones[ch] += int'(pdm[ch]);
      end
    end
    for (int ch = 0; ch < PDM_CHANNELS; ch++) begin
      expect_value(ones[ch], ref_pdm_ones(m_pdm[ch], PDM_RANGE), "PDM ones in one period");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] w;
    lfsr = 32'h72b8_8444;
    m_loop = '0;
    m_gen = '{default: '0};
    m_pdm = '0;
    top_rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = REG_ID;
    wb_dat_w = '0;
    adc_dat = '0;
    repeat (RST_CYCLES) @(negedge adc_clk);
    top_rst = 1'b0;
    check_dac_codes("DAC code after reset");
    // Identification and unmapped space
    read_and_expect(REG_ID, "ID register");
    read_and_expect(3'd7, "unmapped address");
    bus_write(REG_ID, rand_bits(32));
    read_and_expect(REG_ID, "ID register after write");
    // Configuration read-back
    repeat (RAND_ROUNDS) begin
      bus_write(REG_LOOP, rand_bits(32));
      bus_write(REG_GEN0, rand_bits(32));
      bus_write(REG_GEN1, rand_bits(32));
      bus_write(REG_PDM, rand_bits(32));
      read_and_expect(REG_LOOP, "loopback register");
      read_and_expect(REG_GEN0, "generator level 0");
      read_and_expect(REG_GEN1, "generator level 1");
      read_and_expect(REG_PDM, "PDM levels");
      check_dac_codes("DAC code after generator writes");
    end
    bus_write(REG_LOOP, 32'h0);
    // Converted ADC input with loopback off
    repeat (ADC_ROUNDS) begin
      adc_dat[0] = adc_word_t'(rand_bits(ADC_WIDTH));
      adc_dat[1] = adc_word_t'(rand_bits(ADC_WIDTH));
      repeat (4) @(negedge adc_clk);
      read_and_expect(REG_ADC0, "ADC sample 0");
      read_and_expect(REG_ADC1, "ADC sample 1");
    end
    // Loopback set per channel and then cleared again
    for (int ch = 0; ch < NUM_ADC; ch++) begin
      bus_write(3'(REG_GEN0 + ch), rand_bits(32));
      bus_write(REG_LOOP, 32'(1 << ch));
      adc_dat[0] = adc_word_t'(rand_bits(ADC_WIDTH));
      adc_dat[1] = adc_word_t'(rand_bits(ADC_WIDTH));
      repeat (4) @(negedge adc_clk);
      read_and_expect(REG_ADC0, "ADC sample 0 with one loopback set");
      read_and_expect(REG_ADC1, "ADC sample 1 with one loopback set");
      bus_write(REG_LOOP, 32'h0);
      repeat (4) @(negedge adc_clk);
      read_and_expect(3'(REG_ADC0 + ch), "ADC sample after loopback cleared");
    end
    // DAC code one cycle after the acking edge
    repeat (DAC_ROUNDS) begin
      bus_write(REG_GEN0, rand_bits(32));
      bus_write(REG_GEN1, rand_bits(32));
      @(negedge adc_clk);
      check_dac_codes("DAC code one cycle after write");
    end
    // Levels 0, 1, 128 and 255 first
    for (int r = 0; r < PDM_ROUNDS; r++) begin
      w = (r == 0) ? 32'hFF80_0100 : rand_bits(32);
      bus_write(REG_PDM, w);
      repeat (4) @(negedge adc_clk);
      count_pdm_ones();
    end
    @(negedge adc_clk);
    if (n_checked == n_expected && got_q.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Only %0d of %0d results were compared", n_checked, n_expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Results left unchecked");
    end
  end

  initial begin : watchdog
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Timeout, the run did not finish within %0d cycles", RUN_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- analog_front_top.f
logic/afe_pkg.sv
logic/afe_reg_decode.sv
logic/adc_sample_path.sv
logic/dac_code_format.sv
logic/pdm_modulator.sv
logic/analog_front_top.sv
sim/analog_front_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the analog front end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module analog_front_tb -Mdir obj_dir -o analog_front_sim \
  -f analog_front_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/analog_front_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
